//--- logic/branch_pkg.sv
// Shared widths, configuration address map and the structs and union
// used across the multi-way branch unit

`default_nettype none

package branch_pkg;

    localparam int WORD_WIDTH       = 32;
    localparam int PC_WIDTH         = 10;
    localparam int BRANCH_COUNT     = 2;
    localparam int GROUP_WIDTH      = 4;

    // Configuration address is {branch index, offset}
    localparam int CFG_ADDR_WIDTH   = 4;
    localparam int CFG_OFFSET_WIDTH = 3;
    localparam int CFG_BRANCH_WIDTH = CFG_ADDR_WIDTH - CFG_OFFSET_WIDTH;

    localparam logic [CFG_OFFSET_WIDTH-1:0] CFG_S1_VALUE = 3'd0;
    localparam logic [CFG_OFFSET_WIDTH-1:0] CFG_S1_MASK  = 3'd1;
    localparam logic [CFG_OFFSET_WIDTH-1:0] CFG_S2_VALUE = 3'd2;
    localparam logic [CFG_OFFSET_WIDTH-1:0] CFG_S2_MASK  = 3'd3;
    localparam logic [CFG_OFFSET_WIDTH-1:0] CFG_DETECTOR = 3'd4;
    localparam logic [CFG_OFFSET_WIDTH-1:0] CFG_COUNTER  = 3'd5;

    // Flags of the previous instruction, already aligned by the pipeline
    typedef struct packed {
        logic negative;
        logic carryout;
        logic lessthan;
        logic external_a;
        logic external_b;
    } branch_flags_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0] origin;
        logic [PC_WIDTH-1:0] destination;
        logic                predict_enable;
        logic                predict_taken;
        logic [1:0]          a_select;
        logic [1:0]          b_select;
        // Truth table, indexed by {a, b}
        logic [3:0]          ab_operator;
    } branch_detector_cfg_t;

    // One write word, seen raw or as a detector setting
    typedef union packed {
        logic [WORD_WIDTH-1:0] raw;
        struct packed {
            logic [1:0]           spare;
            branch_detector_cfg_t detector;
        } setting;
    } branch_cfg_word_u;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] value;
        logic [WORD_WIDTH-1:0] mask;
    } branch_sentinel_t;

    typedef struct packed {
        branch_sentinel_t      sentinel_1;
        branch_sentinel_t      sentinel_2;
        branch_detector_cfg_t  detector;
        logic                  counter_load;
        logic [WORD_WIDTH-1:0] counter_value;
    } branch_setup_t;

    typedef struct packed {
        logic                reached;
        logic                jump;
        logic                cancel;
        logic [PC_WIDTH-1:0] destination;
    } branch_decision_t;

endpackage

`default_nettype wire

//--- logic/branch_config_regs.sv
// Configuration register block: write decode, sentinel and detector
// storage, and counter load pulses for every branch module

`timescale 1ns/100ps
`default_nettype none

module branch_config_regs (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                cfg_wren,
    input  logic [branch_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [branch_pkg::WORD_WIDTH-1:0]   cfg_data,
    output branch_pkg::branch_setup_t           setup [branch_pkg::BRANCH_COUNT]
);

    import branch_pkg::*;

    logic [CFG_BRANCH_WIDTH-1:0] cfg_branch;
    logic [CFG_OFFSET_WIDTH-1:0] cfg_offset;
    branch_cfg_word_u            cfg_word;

    // ----------------------------------------------------------
    // Address split and word view
    // ----------------------------------------------------------

    assign cfg_branch = cfg_addr[CFG_ADDR_WIDTH-1:CFG_OFFSET_WIDTH];
    assign cfg_offset = cfg_addr[CFG_OFFSET_WIDTH-1:0];
    assign cfg_word   = cfg_data;

    // ----------------------------------------------------------
    // Per-branch registers
    // ----------------------------------------------------------

    for (genvar b = 0; b < BRANCH_COUNT; b++) begin : g_branch

        logic branch_wren;

        assign branch_wren = cfg_wren && (cfg_branch == CFG_BRANCH_WIDTH'(b));

        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                setup[b] <= '0;
            end else begin
                // Load strobe lasts a single cycle
                setup[b].counter_load <= 1'b0;
                if (branch_wren) begin
                    case (cfg_offset)
                        CFG_S1_VALUE: begin
                            setup[b].sentinel_1.value <= cfg_word.raw;
                        end
                        CFG_S1_MASK: begin
                            setup[b].sentinel_1.mask <= cfg_word.raw;
                        end
                        CFG_S2_VALUE: begin
                            setup[b].sentinel_2.value <= cfg_word.raw;
                        end
                        CFG_S2_MASK: begin
                            setup[b].sentinel_2.mask <= cfg_word.raw;
                        end
                        CFG_DETECTOR: begin
                            // Upper two bits of the word are spare
                            setup[b].detector <= cfg_word.setting.detector;
                        end
                        CFG_COUNTER: begin
                            setup[b].counter_load  <= 1'b1;
                            setup[b].counter_value <= cfg_word.raw;
                        end
                        default: begin
                            // Unmapped offsets are ignored
                        end
                    endcase
                end
            end
        end

    end

endmodule

`default_nettype wire

//--- logic/branch_detector.sv
// Branch detector: origin compare, flag selection, condition table
// and the prediction and cancel rule

`timescale 1ns/100ps
`default_nettype none

module branch_detector (
    input  logic [branch_pkg::PC_WIDTH-1:0]    pc,
    input  logic                               io_ready,
    input  logic [branch_pkg::GROUP_WIDTH-1:0] group_a,
    input  logic [branch_pkg::GROUP_WIDTH-1:0] group_b,
    input  branch_pkg::branch_detector_cfg_t   cfg,
    output logic                               reached,
    output branch_pkg::branch_decision_t       decision
);

    logic flag_a;
    logic flag_b;
    logic condition;

    // ----------------------------------------------------------
    // Origin compare
    // ----------------------------------------------------------

    // An instruction annulled by I/O never reaches the branch
    assign reached = io_ready && (pc == cfg.origin);

    // ----------------------------------------------------------
    // Condition
    // ----------------------------------------------------------

    assign flag_a = group_a[cfg.a_select];
    assign flag_b = group_b[cfg.b_select];

    // a forms the upper index bit
    assign condition = cfg.ab_operator[{flag_a, flag_b}];

    // ----------------------------------------------------------
    // Jump and cancel
    // ----------------------------------------------------------

    always_comb begin
        decision.reached     = reached;
        decision.destination = cfg.destination;
        if (cfg.predict_enable) begin
            // Jump early on the guess, cancel if the guess was wrong
            decision.jump   = reached && cfg.predict_taken;
            decision.cancel = reached && (condition != cfg.predict_taken);
        end else begin
            decision.jump   = reached && condition;
            decision.cancel = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/branch_counter.sv
// Loadable loop counter, decremented on reached branches

`timescale 1ns/100ps
`default_nettype none

module branch_counter (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            reached,
    input  logic                            load,
    input  logic [branch_pkg::WORD_WIDTH-1:0] load_value,
    output logic                            running
);

    import branch_pkg::*;

    logic [WORD_WIDTH-1:0] count;

    // Condition sees the count as it was before this edge
    assign running = (count != '0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (reached && running) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/branch_module.sv
// One parallel branch: sentinel compares, flag groups, detector
// and loop counter

`timescale 1ns/100ps
`default_nettype none

module branch_module (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic [branch_pkg::PC_WIDTH-1:0] pc,
    input  logic                            io_ready,
    input  branch_pkg::branch_flags_t       flags_previous,
    input  logic [branch_pkg::WORD_WIDTH-1:0] result_previous,
    input  branch_pkg::branch_setup_t       setup,
    output branch_pkg::branch_decision_t    decision
);

    import branch_pkg::*;

    logic                   s1_match;
    logic                   s2_match;
    logic                   running;
    logic                   reached;
    logic [GROUP_WIDTH-1:0] group_a;
    logic [GROUP_WIDTH-1:0] group_b;

    // ----------------------------------------------------------
    // Sentinels
    // ----------------------------------------------------------

    // Mask bits set to 1 are don't-care
    assign s1_match = ((result_previous ^ setup.sentinel_1.value)
                       & ~setup.sentinel_1.mask) == '0;
    assign s2_match = ((result_previous ^ setup.sentinel_2.value)
                       & ~setup.sentinel_2.mask) == '0;

    // ----------------------------------------------------------
    // Flag groups, select 0 at bit 0
    // ----------------------------------------------------------

    assign group_a = {flags_previous.external_a, s1_match,
                      flags_previous.carryout, flags_previous.negative};
    assign group_b = {flags_previous.external_b, s2_match,
                      running, flags_previous.lessthan};

    branch_detector u_detector (
        .pc       (pc),
        .io_ready (io_ready),
        .group_a  (group_a),
        .group_b  (group_b),
        .cfg      (setup.detector),
        .reached  (reached),
        .decision (decision)
    );

    branch_counter u_counter (
        .clock      (clock),
        .rst_n      (rst_n),
        .reached    (reached),
        .load       (setup.counter_load),
        .load_value (setup.counter_value),
        .running    (running)
    );

endmodule

`default_nettype wire

//--- logic/branch_arbiter.sv
// Fixed-priority merge of branch decisions into registered outputs

`timescale 1ns/100ps
`default_nettype none

module branch_arbiter (
    input  logic                            clock,
    input  logic                            rst_n,
    input  branch_pkg::branch_decision_t    decision [branch_pkg::BRANCH_COUNT],
    output logic                            jump,
    output logic [branch_pkg::PC_WIDTH-1:0] destination,
    output logic                            cancel
);

    import branch_pkg::*;

    branch_decision_t selected;

    // Walk downwards so the lowest reached index wins
    always_comb begin
        selected = '0;
        for (int i = BRANCH_COUNT - 1; i >= 0; i--) begin
            if (decision[i].reached) begin
                selected = decision[i];
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            jump        <= 1'b0;
            cancel      <= 1'b0;
            destination <= '0;
        end else begin
            jump        <= selected.jump;
            cancel      <= selected.cancel;
            destination <= selected.destination;
        end
    end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
// Branch unit top: register block, two branch modules and arbiter

`timescale 1ns/100ps
`default_nettype none

module branch_unit (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic [branch_pkg::PC_WIDTH-1:0]       pc,
    input  logic                                  io_ready,
    input  branch_pkg::branch_flags_t             flags_previous,
    input  logic [branch_pkg::WORD_WIDTH-1:0]     result_previous,
    input  logic                                  cfg_wren,
    input  logic [branch_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [branch_pkg::WORD_WIDTH-1:0]     cfg_data,
    output logic                                  jump,
    output logic [branch_pkg::PC_WIDTH-1:0]       destination,
    output logic                                  cancel
);

    import branch_pkg::*;

    branch_setup_t    setup    [BRANCH_COUNT];
    branch_decision_t decision [BRANCH_COUNT];

    // ----------------------------------------------------------
    // Configuration
    // ----------------------------------------------------------

    branch_config_regs u_config_regs (
        .clock    (clock),
        .rst_n    (rst_n),
        .cfg_wren (cfg_wren),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .setup    (setup)
    );

    // ----------------------------------------------------------
    // Parallel branches
    // ----------------------------------------------------------

    branch_module u_branch_0 (
        .clock           (clock),
        .rst_n           (rst_n),
        .pc              (pc),
        .io_ready        (io_ready),
        .flags_previous  (flags_previous),
        .result_previous (result_previous),
        .setup           (setup[0]),
        .decision        (decision[0])
    );

    branch_module u_branch_1 (
        .clock           (clock),
        .rst_n           (rst_n),
        .pc              (pc),
        .io_ready        (io_ready),
        .flags_previous  (flags_previous),
        .result_previous (result_previous),
        .setup           (setup[1]),
        .decision        (decision[1])
    );

    // Branch 0 has priority
    branch_arbiter u_arbiter (
        .clock       (clock),
        .rst_n       (rst_n),
        .decision    (decision),
        .jump        (jump),
        .destination (destination),
        .cancel      (cancel)
    );

endmodule

`default_nettype wire

//--- tests/branch_unit_sva.sv
// Concurrent assertions on the branch unit outputs

`timescale 1ns/100ps
`default_nettype none

module branch_unit_sva (
    input logic                                  clock,
    input logic                                  rst_n,
    input logic                                  jump,
    input logic                                  cancel,
    input logic [branch_pkg::PC_WIDTH-1:0]       destination,
    input logic [branch_pkg::BRANCH_COUNT-1:0]   predict_enable
);

    // Covers reset itself and the first cycle after release
    reset_quiet: assert property (@(posedge clock) !rst_n |=> !jump && !cancel)
        else $error("jump or cancel high during or just after reset");

    // Cancel is registered from the detector setting of the cycle before
    cancel_needs_prediction: assert property (@(posedge clock) disable iff (!rst_n)
        cancel |-> $past(|predict_enable))
        else $error("cancel raised with no detector predicting");

    outputs_known: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown({jump, cancel, destination}))
        else $error("unknown value on the branch outputs");

endmodule

bind branch_unit branch_unit_sva u_sva (
    .clock          (clock),
    .rst_n          (rst_n),
    .jump           (jump),
    .cancel         (cancel),
    .destination    (destination),
    .predict_enable ({setup[1].detector.predict_enable, setup[0].detector.predict_enable})
);

`default_nettype wire

//--- tests/branch_unit_tb.sv
// Branch unit testbench: stimulus tasks, shadow configuration model,
// reference function, compare process and regression report

`timescale 1ns/100ps
`default_nettype none

module branch_unit_tb;

    import branch_pkg::*;

    logic                      clock = 1'b0;
    logic                      rst_n = 1'b0;
    logic [PC_WIDTH-1:0]       pc = '0;
    logic                      io_ready = 1'b0;
    branch_flags_t             flags_previous = '0;
    logic [WORD_WIDTH-1:0]     result_previous = '0;
    logic                      cfg_wren = 1'b0;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr = '0;
    logic [WORD_WIDTH-1:0]     cfg_data = '0;
    logic                      jump;
    logic [PC_WIDTH-1:0]       destination;
    logic                      cancel;

    // Shadow of the configuration registers and loop counts
    logic [WORD_WIDTH-1:0] sent_value   [BRANCH_COUNT][2];
    logic [WORD_WIDTH-1:0] sent_mask    [BRANCH_COUNT][2];
    branch_detector_cfg_t  det          [BRANCH_COUNT];
    logic [WORD_WIDTH-1:0] count        [BRANCH_COUNT];
    logic [WORD_WIDTH-1:0] load_value   [BRANCH_COUNT];
    logic                  load_pending [BRANCH_COUNT];
    branch_decision_t      expected;
    branch_decision_t      predicted;
    logic                  expect_valid = 1'b0;

    integer seed        = 32'h960e_f929;
    int     error_count = 0;
    int     test_count  = 0;
    int     cycle_count = 0;
    int     jump_total  = 0;
    int     test_mark   = 0;

    branch_unit u_branch_unit (.*);

    always #10 clock = ~clock;

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    // One branch, evaluated on the inputs applied in this cycle
    function automatic branch_decision_t model_branch(int b);
        branch_decision_t d;
        logic [1:0]       match;
        logic             flag_a;
        logic             flag_b;
        logic [1:0]       idx;
        logic             cond;
        for (int s = 0; s < 2; s++) begin
            match[s] = (result_previous | sent_mask[b][s]) == (sent_value[b][s] | sent_mask[b][s]);
        end
        case (det[b].a_select)
            2'd0: flag_a = flags_previous.negative;
            2'd1: flag_a = flags_previous.carryout;
            2'd2: flag_a = match[0];
            default: flag_a = flags_previous.external_a;
        endcase
        case (det[b].b_select)
            2'd0: flag_b = flags_previous.lessthan;
            2'd1: flag_b = (count[b] != '0);
            2'd2: flag_b = match[1];
            default: flag_b = flags_previous.external_b;
        endcase
        idx  = {flag_a, flag_b};
        cond = det[b].ab_operator[idx];
        d.reached     = io_ready && (pc == det[b].origin);
        d.destination = det[b].destination;
        d.jump   = d.reached && (det[b].predict_enable ? det[b].predict_taken : cond);
        d.cancel = d.reached && det[b].predict_enable && (cond != det[b].predict_taken);
        return d;
    endfunction

    // Lowest reached branch wins, nothing reached gives all zero
    function automatic branch_decision_t model_unit();
        branch_decision_t d;
        d = '0;
        for (int b = BRANCH_COUNT - 1; b >= 0; b--) begin
            if (io_ready && (pc == det[b].origin)) begin
                d = model_branch(b);
            end
        end
        return d;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] want);
        if (actual !== want) begin
            error_count++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, want);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clock) begin : compare_outputs
        if (!rst_n) begin
            sent_value   = '{default: '0};
            sent_mask    = '{default: '0};
            det          = '{default: '0};
            count        = '{default: '0};
            load_value   = '{default: '0};
            load_pending = '{default: 1'b0};
            expect_valid = 1'b0;
        end else begin
            if (expect_valid) begin
                compare_value("jump", 32'(jump), 32'(expected.jump));
                compare_value("cancel", 32'(cancel), 32'(expected.cancel));
                if (expected.jump || expected.cancel) begin
                    compare_value("destination", 32'(destination), 32'(expected.destination));
                end
            end
            if (jump) begin
                jump_total++;
            end
            predicted = model_unit();
            // State as it stands after the coming rising edge
            for (int b = 0; b < BRANCH_COUNT; b++) begin
                if (load_pending[b]) begin
                    count[b] = load_value[b];
                end else if (io_ready && (pc == det[b].origin) && (count[b] != '0)) begin
                    count[b] = count[b] - 1;
                end
                load_pending[b] = 1'b0;
            end
            if (cfg_wren) begin
                case (cfg_addr[2:0])
                    CFG_S1_VALUE: sent_value[cfg_addr[3]][0] = cfg_data;
                    CFG_S1_MASK:  sent_mask[cfg_addr[3]][0]  = cfg_data;
                    CFG_S2_VALUE: sent_value[cfg_addr[3]][1] = cfg_data;
                    CFG_S2_MASK:  sent_mask[cfg_addr[3]][1]  = cfg_data;
                    CFG_DETECTOR: det[cfg_addr[3]] = cfg_data[29:0];
                    CFG_COUNTER: begin
                        load_pending[cfg_addr[3]] = 1'b1;
                        load_value[cfg_addr[3]]   = cfg_data;
                    end
                    default: begin
                    end
                endcase
            end
            expected     = predicted;
            expect_valid = 1'b1;
        end
    end

    // Tests take about 2600 cycles
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= 5000) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    function automatic logic [WORD_WIDTH-1:0] random_word();
        return $random(seed);
    endfunction

    task automatic write_cfg(input int branch, input logic [2:0] offset,
                             input logic [WORD_WIDTH-1:0] data);
        @(posedge clock);
        cfg_wren <= 1'b1;
        cfg_addr <= {branch[0], offset};
        cfg_data <= data;
        @(posedge clock);
        cfg_wren <= 1'b0;
    endtask

    // Destination and predict_taken are random
    task automatic write_detector(input int branch, input logic [PC_WIDTH-1:0] origin,
                                  input logic predict_enable, input logic [1:0] a_select,
                                  input logic [1:0] b_select, input logic [3:0] ab_operator);
        logic [WORD_WIDTH-1:0] word;
        word = random_word();
        write_cfg(branch, CFG_DETECTOR, {2'b00, origin, word[PC_WIDTH-1:0], predict_enable,
                                         word[10], a_select, b_select, ab_operator});
    endtask

    // Random cycles, half of them at one of the two origins
    task automatic run_cycles(input int cycles, input logic [PC_WIDTH-1:0] origin_a,
                              input logic [PC_WIDTH-1:0] origin_b,
                              input logic [WORD_WIDTH-1:0] near_value,
                              input logic [WORD_WIDTH-1:0] near_mask);
        logic [WORD_WIDTH-1:0] pick;
        logic [WORD_WIDTH-1:0] noise;
        repeat (cycles) begin
            pick  = random_word();
            noise = random_word();
            @(posedge clock);
            case (pick[1:0])
                2'd0: pc <= origin_a;
                2'd1: pc <= origin_b;
                default: pc <= noise[PC_WIDTH-1:0];
            endcase
            io_ready        <= (pick[3:2] != 2'b00);
            flags_previous  <= pick[8:4];
            result_previous <= pick[9] ? ((near_value & ~near_mask) | (noise & near_mask)) : noise;
        end
    endtask

    task automatic visit_origin(input int visits, input logic [PC_WIDTH-1:0] origin);
        logic [WORD_WIDTH-1:0] word;
        repeat (visits) begin
            word = random_word();
            @(posedge clock);
            pc             <= origin;
            io_ready       <= 1'b1;
            flags_previous <= word[4:0];
            @(posedge clock);
            pc <= origin + 10'd1;
        end
    endtask

    task automatic finish_test(input string name);
        repeat (2) @(posedge clock);
        test_count++;
        $display("Test %s finished with %0d errors", name, error_count - test_mark);
        test_mark = error_count;
    endtask

    initial begin
        logic [WORD_WIDTH-1:0] word;
        logic [WORD_WIDTH-1:0] v;
        logic [WORD_WIDTH-1:0] m;
        logic [PC_WIDTH-1:0]   org;
        int                    n;
        int                    start;
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;

        run_cycles(100, 10'd0, 10'd1, '0, '0);
        finish_test("reset idle");

        for (int r = 0; r < 40; r++) begin
            word = random_word();
            org  = word[PC_WIDTH-1:0];
            write_detector(0, org, 1'b0, word[11:10], word[13:12], word[17:14]);
            run_cycles(12, org, org + 10'd1, word, random_word());
        end
        finish_test("unpredicted conditions");

        for (int r = 0; r < 20; r++) begin
            v    = random_word();
            m    = random_word() & random_word();
            word = random_word();
            write_cfg(0, r[0] ? CFG_S2_VALUE : CFG_S1_VALUE, v);
            write_cfg(0, r[0] ? CFG_S2_MASK : CFG_S1_MASK, m);
            write_detector(0, org, 1'b0, 2'd2, 2'd2, word[3:0]);
            run_cycles(12, org, org, v, m);
        end
        finish_test("sentinels");

        // Condition is b alone, with b the running flag
        for (int rep = 0; rep < 8; rep++) begin
            org = 10'(100 + 4 * rep);
            write_detector(1, org, 1'b0, 2'd0, 2'd1, 4'b1010);
            write_detector(0, ~org, 1'b0, 2'd0, 2'd0, 4'b0000);
            n = 1 + int'(random_word() % 32'd6);
            write_cfg(1, CFG_COUNTER, n);
            if (rep[0]) begin
                visit_origin(2, org);
                write_cfg(1, CFG_COUNTER, n);
            end
            start = jump_total;
            visit_origin(n + 2, org);
            repeat (2) @(posedge clock);
            compare_value("loop jumps", jump_total - start, n);
        end
        finish_test("loop counter");

        for (int r = 0; r < 40; r++) begin
            word = random_word();
            write_detector(0, word[9:0], 1'b1, word[21:20], word[23:22], word[27:24]);
            write_detector(1, word[19:10], 1'b1, word[23:22], word[21:20], word[31:28]);
            run_cycles(12, word[9:0], word[19:10], v, m);
        end
        finish_test("prediction");

        for (int r = 0; r < 40; r++) begin
            word = random_word();
            org  = word[31] ? word[9:0] : word[19:10];
            write_detector(0, word[9:0], word[28], word[21:20], word[23:22], word[27:24]);
            write_detector(1, org, word[29], word[23:22], word[21:20], word[3:0]);
            run_cycles(12, word[9:0], org, v, m);
        end
        finish_test("arbitration");

        $display("Summary: %0d tests, %0d errors, %0d cycles", test_count, error_count,
                 cycle_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/branch_pkg.sv
logic/branch_config_regs.sv
logic/branch_detector.sv
logic/branch_counter.sv
logic/branch_module.sv
logic/branch_arbiter.sv
logic/branch_unit.sv
tests/branch_unit_sva.sv
tests/branch_unit_tb.sv

//--- Makefile
# Verilator build, run and lint for the branch unit

VERILATOR  ?= verilator
TOP        := branch_unit_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
